//--- Makefile
TOP = butterworth_iir_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- logic/biquad_cascade.sv
`timescale 1ns/1ps

module biquad_cascade
#(
   parameter int fb11 = iir_pkg::FB11,
   parameter int fb12 = iir_pkg::FB12,
   parameter int fb21 = iir_pkg::FB21,
   parameter int fb22 = iir_pkg::FB22
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    clken,
   input  logic signed [iir_pkg::DLY_WIDTH-1:0]    xn,
   output logic signed [iir_pkg::OUTPUT_WIDTH-1:0] cascade_out
);

   import iir_pkg::*;

   // Section 1 output, SBF 17.4
   logic signed [OUTPUT_WIDTH-1:0] sec1_y;

   // Interstage register feeding section 2, SBF 14.4
   logic signed [DLY_WIDTH-1:0] interstage;

   // First pole pair
   iir_biquad #(
      .fb1 (fb11),
      .fb2 (fb12)
   ) section1 (
      .clk   (clk),
      .reset (reset),
      .clken (clken),
      .x     (xn),
      .y     (sec1_y)
   );

   // Truncate back to the input delay width
   // Top three integer bits are dropped, so large values wrap
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         interstage <= '0;
      end
      else if (clken)
      begin
         interstage <= sec1_y[DLY_WIDTH-1:0];
      end
   end

   // Second pole pair, output goes straight to the gain stage
   iir_biquad #(
      .fb1 (fb21),
      .fb2 (fb22)
   ) section2 (
      .clk   (clk),
      .reset (reset),
      .clken (clken),
      .x     (interstage),
      .y     (cascade_out)
   );

endmodule

//--- logic/butterworth_iir.sv
`timescale 1ns/1ps

module butterworth_iir
#(
   parameter int fb11 = iir_pkg::FB11,
   parameter int fb12 = iir_pkg::FB12,
   parameter int fb21 = iir_pkg::FB21,
   parameter int fb22 = iir_pkg::FB22,
   parameter int gain = iir_pkg::GAIN
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    clken,
   input  logic signed [iir_pkg::INPUT_WIDTH-1:0]  x,
   output logic signed [iir_pkg::OUTPUT_WIDTH-1:0] result,
   output logic                                    result_valid
);

   import iir_pkg::*;

   // Aligned sample, SBF 14.4
   logic signed [DLY_WIDTH-1:0] xn;
   // Unscaled filter output, SBF 17.4
   logic signed [OUTPUT_WIDTH-1:0] cascade_out;

   // Input side, one strobe edge
   sample_conditioner i_sample_conditioner (
      .clk   (clk),
      .reset (reset),
      .clken (clken),
      .x     (x),
      .xn    (xn)
   );

   // Two second-order sections, three strobe edges
   biquad_cascade #(
      .fb11 (fb11),
      .fb12 (fb12),
      .fb21 (fb21),
      .fb22 (fb22)
   ) i_biquad_cascade (
      .clk         (clk),
      .reset       (reset),
      .clken       (clken),
      .xn          (xn),
      .cascade_out (cascade_out)
   );

   // Output side, gain and fill flag
   gain_scaler #(
      .gain (gain)
   ) i_gain_scaler (
      .clk          (clk),
      .reset        (reset),
      .clken        (clken),
      .cascade_out  (cascade_out),
      .result       (result),
      .result_valid (result_valid)
   );

endmodule

//--- logic/gain_scaler.sv
`timescale 1ns/1ps

module gain_scaler
#(
   parameter int gain = iir_pkg::GAIN
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    clken,
   input  logic signed [iir_pkg::OUTPUT_WIDTH-1:0] cascade_out,
   output logic signed [iir_pkg::OUTPUT_WIDTH-1:0] result,
   output logic                                    result_valid
);

   import iir_pkg::*;

   localparam int out_ext = ACC_WIDTH - OUTPUT_WIDTH;
   localparam int cnt_width = $clog2(PIPE_DEPTH);
   // Last count before the flag goes up
   localparam logic [cnt_width-1:0] fill_last = cnt_width'(PIPE_DEPTH - 1);

   // Gain in SBF 0.10 at product width
   localparam logic signed [ACC_WIDTH-1:0] gain_c = ACC_WIDTH'(gain);

   logic signed [ACC_WIDTH-1:0] cascade_ext;
   logic signed [ACC_WIDTH-1:0] product;

   // Strobe edges seen since reset, stops at fill_last
   logic [cnt_width-1:0] fill_cnt;

   assign cascade_ext = {{out_ext{cascade_out[OUTPUT_WIDTH-1]}}, cascade_out};
   assign product = cascade_ext * gain_c;

   // Result register, same slice as inside the biquads
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         result <= '0;
      end
      else if (clken)
      begin
         result <= product[H_BIT:L_BIT];
      end
   end

   // Pipeline fill
   // Flag rises on the fifth strobe edge, then sticks until reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fill_cnt     <= '0;
         result_valid <= 1'b0;
      end
      else if (clken)
      begin
         if (fill_cnt == fill_last)
         begin
            result_valid <= 1'b1;
         end
         else
         begin
            fill_cnt <= fill_cnt + 1'b1;
         end
      end
   end

endmodule

//--- logic/iir_biquad.sv
`timescale 1ns/1ps

module iir_biquad
#(
   parameter int fb1 = iir_pkg::FB11,
   parameter int fb2 = iir_pkg::FB12
)
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    clken,
   input  logic signed [iir_pkg::DLY_WIDTH-1:0]    x,
   output logic signed [iir_pkg::OUTPUT_WIDTH-1:0] y
);

   import iir_pkg::*;

   // Extension widths up to the accumulator
   localparam int dly_ext = ACC_WIDTH - DLY_WIDTH;
   localparam int out_ext = ACC_WIDTH - OUTPUT_WIDTH;

   // Coefficients at accumulator width, SBF 0.10 scaling
   localparam logic signed [ACC_WIDTH-1:0] ff0_c = ACC_WIDTH'(FF0);
   localparam logic signed [ACC_WIDTH-1:0] ff1_c = ACC_WIDTH'(FF1);
   localparam logic signed [ACC_WIDTH-1:0] ff2_c = ACC_WIDTH'(FF2);
   localparam logic signed [ACC_WIDTH-1:0] fb1_c = ACC_WIDTH'(fb1);
   localparam logic signed [ACC_WIDTH-1:0] fb2_c = ACC_WIDTH'(fb2);

   // Input delay line, SBF 14.4
   logic signed [DLY_WIDTH-1:0] x1;
   logic signed [DLY_WIDTH-1:0] x2;

   // Second output delay, y itself serves as the first
   logic signed [OUTPUT_WIDTH-1:0] y2;

   // Operands sign-extended to accumulator width
   logic signed [ACC_WIDTH-1:0] x0_ext;
   logic signed [ACC_WIDTH-1:0] x1_ext;
   logic signed [ACC_WIDTH-1:0] x2_ext;
   logic signed [ACC_WIDTH-1:0] y1_ext;
   logic signed [ACC_WIDTH-1:0] y2_ext;

   // Five-term sum, wraps at 32 bits
   logic signed [ACC_WIDTH-1:0] acc;

   assign x0_ext = {{dly_ext{x[DLY_WIDTH-1]}}, x};
   assign x1_ext = {{dly_ext{x1[DLY_WIDTH-1]}}, x1};
   assign x2_ext = {{dly_ext{x2[DLY_WIDTH-1]}}, x2};
   assign y1_ext = {{out_ext{y[OUTPUT_WIDTH-1]}}, y};
   assign y2_ext = {{out_ext{y2[OUTPUT_WIDTH-1]}}, y2};

   // Direct form I
   // Numerator taps on the inputs, denominator taps on past outputs
   assign acc = ff0_c * x0_ext
              + ff1_c * x1_ext
              + ff2_c * x2_ext
              - fb1_c * y1_ext
              - fb2_c * y2_ext;

   // All state advances together on the strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         x1 <= '0;
         x2 <= '0;
         y  <= '0;
         y2 <= '0;
      end
      else if (clken)
      begin
         // Drop the coefficient fraction, keep SBF 17.4
         y  <= acc[H_BIT:L_BIT];
         // Shift both delay lines by one sample
         x1 <= x;
         x2 <= x1;
         y2 <= y;
      end
   end

endmodule

//--- logic/iir_pkg.sv
package iir_pkg;

   // Raw sample from the converter, two's complement
   localparam int INPUT_WIDTH = 12;

   // Fraction bits appended to each raw sample
   localparam int F_BITS = 4;

   // Aligned sample and biquad input delays, SBF 14.4
   localparam int DLY_WIDTH = 18;

   // Biquad outputs and final result, SBF 17.4
   localparam int OUTPUT_WIDTH = 21;

   // Coefficient scaling, 1.0 maps to 2**COEF_WIDTH
   localparam int COEF_WIDTH = 10;

   // Signed width of every accumulator and of the gain product
   localparam int ACC_WIDTH = 32;

   // Slice kept from an accumulator, shift right by the coefficient scale
   localparam int L_BIT = COEF_WIDTH;
   localparam int H_BIT = L_BIT + OUTPUT_WIDTH - 1;

   // Clock-enable edges from sampling a value to its result
   // Input reg, section 1, interstage, section 2, result reg
   localparam int PIPE_DEPTH = 5;

   // Feedforward taps shared by both sections, 1 2 1 in SBF 0.10
   localparam int FF0 = 1 << COEF_WIDTH;
   localparam int FF1 = 2 << COEF_WIDTH;
   localparam int FF2 = 1 << COEF_WIDTH;

   // Section 1 feedback, about 0.329 and 0.0646
   localparam int FB11 = 337;
   localparam int FB12 = 66;

   // Section 2 feedback, about 0.4531 and 0.4663
   localparam int FB21 = 464;
   localparam int FB22 = 478;

   // Overall gain, about 0.1672
   localparam int GAIN = 171;

endpackage

//--- logic/sample_conditioner.sv
`timescale 1ns/1ps

module sample_conditioner
(
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   clken,
   input  logic signed [iir_pkg::INPUT_WIDTH-1:0] x,
   output logic signed [iir_pkg::DLY_WIDTH-1:0]   xn
);

   import iir_pkg::*;

   // Integer bits to add above the raw sample
   localparam int sign_bits = DLY_WIDTH - INPUT_WIDTH - F_BITS;

   // Aligned form of the current sample before the register
   logic signed [DLY_WIDTH-1:0] x_aligned;

   // Sign extension to 14 integer bits
   // Zero fraction below, so the value is 16 times x
   assign x_aligned = {{sign_bits{x[INPUT_WIDTH-1]}}, x, {F_BITS{1'b0}}};

   // Input register
   // First stage of the pipeline, loads only on the sample strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         xn <= '0;
      end
      else if (clken)
      begin
         xn <= x_aligned;
      end
   end

endmodule

//--- src.f
logic/iir_pkg.sv
logic/sample_conditioner.sv
logic/iir_biquad.sv
logic/biquad_cascade.sv
logic/gain_scaler.sv
logic/butterworth_iir.sv
testbench/butterworth_iir_properties.sv
testbench/butterworth_iir_tb.sv

//--- testbench/butterworth_iir_properties.sv
`timescale 1ns/1ps

module butterworth_iir_properties
(
   input logic                                    clk,
   input logic                                    reset,
   input logic                                    clken,
   input logic signed [iir_pkg::OUTPUT_WIDTH-1:0] result,
   input logic                                    result_valid
);

   // Failed assertion count
   int assert_errors = 0;

   // Outputs frozen across an edge without the strobe
   property hold_without_strobe;
      @(posedge clk) (!reset && !clken) |=> ($stable(result) && $stable(result_valid));
   endproperty

   // Fill flag only drops through reset
   property valid_sticky;
      @(posedge clk) $fell(result_valid) |-> $past(reset);
   endproperty

   // Output side cleared one cycle after reset
   property reset_clears;
      @(posedge clk) reset |=> ((result == '0) && !result_valid);
   endproperty

   a_hold: assert property (hold_without_strobe)
   else
   begin
      assert_errors++;
      $error("result or result_valid changed on an edge with clken low");
   end

   a_sticky: assert property (valid_sticky)
   else
   begin
      assert_errors++;
      $error("result_valid fell without a reset");
   end

   a_reset: assert property (reset_clears)
   else
   begin
      assert_errors++;
      $error("outputs not cleared one cycle after reset");
   end

endmodule

bind butterworth_iir butterworth_iir_properties i_properties (
   .clk          (clk),
   .reset        (reset),
   .clken        (clken),
   .result       (result),
   .result_valid (result_valid)
);

//--- testbench/butterworth_iir_tb.sv
`timescale 1ns/1ps

module butterworth_iir_tb;

   import iir_pkg::*;

   // Cycles per test, one falling edge each
   localparam int reset_cycles   = 4;
   localparam int impulse_cycles = 40;
   localparam int step_cycles    = 200;
   localparam int random_cycles  = 300;
   localparam int mid_pre        = 100;
   localparam int mid_post       = 40;
   localparam int extreme_cycles = 120;
   localparam int drain_cycles   = 10;
   localparam int total_cycles   = 2 * reset_cycles + impulse_cycles + step_cycles
                                 + random_cycles + mid_pre + mid_post + extreme_cycles
                                 + drain_cycles;
   localparam int timeout_limit  = total_cycles + 50;

   logic clk;
   logic reset;
   logic clken;
   logic signed [INPUT_WIDTH-1:0]  x;
   logic signed [OUTPUT_WIDTH-1:0] result;
   logic result_valid;

   string test_name;
   int error_count = 0;
   int cycle_count = 0;
   logic armed = 1'b0;
   logic [31:0] rng_state;

   // Model pipeline state, one copy of every DUT register
   logic signed [DLY_WIDTH-1:0]    m_xn;
   logic signed [DLY_WIDTH-1:0]    m_s1_x1;
   logic signed [DLY_WIDTH-1:0]    m_s1_x2;
   logic signed [OUTPUT_WIDTH-1:0] m_s1_y;
   logic signed [OUTPUT_WIDTH-1:0] m_s1_y2;
   logic signed [DLY_WIDTH-1:0]    m_inter;
   logic signed [DLY_WIDTH-1:0]    m_s2_x1;
   logic signed [DLY_WIDTH-1:0]    m_s2_x2;
   logic signed [OUTPUT_WIDTH-1:0] m_s2_y;
   logic signed [OUTPUT_WIDTH-1:0] m_s2_y2;
   logic signed [OUTPUT_WIDTH-1:0] m_result;
   logic m_valid;
   int m_fill;

   butterworth_iir i_butterworth_iir (
      .clk          (clk),
      .reset        (reset),
      .clken        (clken),
      .x            (x),
      .result       (result),
      .result_valid (result_valid)
   );

   // 40 ns period
   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // One second-order section
   // Wide sum, then bits 30 down to 10 as the 32-bit wrap leaves them
   function automatic logic signed [OUTPUT_WIDTH-1:0] section_out(
      input logic signed [DLY_WIDTH-1:0]    xin,
      input logic signed [DLY_WIDTH-1:0]    xd1,
      input logic signed [DLY_WIDTH-1:0]    xd2,
      input logic signed [OUTPUT_WIDTH-1:0] yd1,
      input logic signed [OUTPUT_WIDTH-1:0] yd2,
      input longint                         fb1,
      input longint                         fb2
   );
      longint sum;
      sum = longint'(FF0) * longint'(xin) + longint'(FF1) * longint'(xd1)
          + longint'(FF2) * longint'(xd2) - fb1 * longint'(yd1) - fb2 * longint'(yd2);
      return sum[H_BIT:L_BIT];
   endfunction

   function automatic void model_reset();
      m_xn     = '0;
      m_s1_x1  = '0;
      m_s1_x2  = '0;
      m_s1_y   = '0;
      m_s1_y2  = '0;
      m_inter  = '0;
      m_s2_x1  = '0;
      m_s2_x2  = '0;
      m_s2_y   = '0;
      m_s2_y2  = '0;
      m_result = '0;
      m_valid  = 1'b0;
      m_fill   = 0;
   endfunction

   // One strobe edge, every new value from the old state
   function automatic void model_step(input logic signed [INPUT_WIDTH-1:0] xin);
      longint ext;
      longint prod;
      logic signed [DLY_WIDTH-1:0]    new_xn;
      logic signed [OUTPUT_WIDTH-1:0] new_s1;
      logic signed [DLY_WIDTH-1:0]    new_inter;
      logic signed [OUTPUT_WIDTH-1:0] new_s2;
      logic signed [OUTPUT_WIDTH-1:0] new_result;
      // Value of the aligned sample is 16 times x
      ext = longint'(xin) * 16;
      new_xn = ext[DLY_WIDTH-1:0];
      new_s1 = section_out(m_xn, m_s1_x1, m_s1_x2, m_s1_y, m_s1_y2, FB11, FB12);
      // Interstage keeps the low bits and wraps
      new_inter = m_s1_y[DLY_WIDTH-1:0];
      new_s2 = section_out(m_inter, m_s2_x1, m_s2_x2, m_s2_y, m_s2_y2, FB21, FB22);
      prod = longint'(m_s2_y) * longint'(GAIN);
      new_result = prod[H_BIT:L_BIT];
      // Delay lines shift before the outputs load
      m_s1_x2  = m_s1_x1;
      m_s1_x1  = m_xn;
      m_s1_y2  = m_s1_y;
      m_s2_x2  = m_s2_x1;
      m_s2_x1  = m_inter;
      m_s2_y2  = m_s2_y;
      m_xn     = new_xn;
      m_s1_y   = new_s1;
      m_inter  = new_inter;
      m_s2_y   = new_s2;
      m_result = new_result;
      if (m_fill < PIPE_DEPTH)
      begin
         m_fill++;
      end
      m_valid = (m_fill >= PIPE_DEPTH);
   endfunction

   task automatic check_value(input string name, input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
      if (actual !== expected)
      begin
         error_count++;
         $display("FAIL %s expected %0d actual %0d", name, expected, actual);
         $display("Test failed");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   // Compare outputs held since the last edge, then advance the model
   always @(posedge clk)
   begin
      if (armed)
      begin
         check_value({test_name, " result"}, 32'(m_result), 32'(result));
         check_value({test_name, " valid"}, 32'(m_valid), 32'(result_valid));
      end
      if (reset)
      begin
         model_reset();
         armed = 1'b1;
      end
      else if (clken)
      begin
         model_step(x);
      end
      if (i_butterworth_iir.i_properties.assert_errors != 0)
      begin
         $display("A bound assertion on the DUT failed");
         $display("Test failed");
         $fatal(1, "Assertion failure");
      end
      cycle_count++;
      if (cycle_count > timeout_limit)
      begin
         $display("Run exceeded %0d cycles without finishing", timeout_limit);
         $display("Test failed");
         $fatal(1, "Timeout");
      end
   end

   // Inputs change on the falling edge only
   task automatic drive_cycle(input logic signed [INPUT_WIDTH-1:0] sample,
                              input logic enable);
      @(negedge clk);
      x = sample;
      clken = enable;
   endtask

   task automatic apply_impulse();
      int i;
      test_name = "impulse";
      drive_cycle(12'sd1000, 1'b1);
      for (i = 1; i < impulse_cycles; i++)
      begin
         drive_cycle('0, 1'b1);
         // i strobe edges since the impulse was sampled
         if (i <= PIPE_DEPTH)
         begin
            check_value("impulse latency", 32'(i >= PIPE_DEPTH), 32'(result != 0));
         end
      end
   endtask

   task automatic hold_step();
      test_name = "step";
      repeat (step_cycles) drive_cycle(12'sd500, 1'b1);
   endtask

   task automatic random_gaps();
      logic [31:0] rnd;
      test_name = "random gaps";
      repeat (random_cycles)
      begin
         rnd = next_random();
         drive_cycle(rnd[11:0], rnd[15:12] > 4'd5);
      end
   endtask

   task automatic reset_midstream();
      logic [31:0] rnd;
      int i;
      test_name = "mid-stream reset";
      repeat (mid_pre)
      begin
         rnd = next_random();
         drive_cycle(rnd[11:0], rnd[15:12] > 4'd5);
      end
      repeat (reset_cycles)
      begin
         rnd = next_random();
         drive_cycle(rnd[11:0], 1'b1);
         reset = 1'b1;
      end
      for (i = 0; i < mid_post; i++)
      begin
         rnd = next_random();
         drive_cycle(rnd[11:0], 1'b1);
         reset = 1'b0;
         if (i == 0)
         begin
            check_value("reset clears result", 32'sd0, 32'(result));
         end
         // Flag back after the fifth strobe edge past reset
         if (i <= PIPE_DEPTH)
         begin
            check_value("reset refill", 32'(i >= PIPE_DEPTH), 32'(result_valid));
         end
      end
   endtask

   task automatic alternate_extremes();
      int i;
      test_name = "extremes";
      for (i = 0; i < extreme_cycles; i++)
      begin
         // 7FF is +2047, 800 is -2048
         drive_cycle(i[0] ? 12'h800 : 12'h7FF, 1'b1);
      end
   endtask

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      clken = 1'b0;
      x = '0;
      rng_state = 32'd38;
      test_name = "reset";
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      apply_impulse();
      hold_step();
      random_gaps();
      reset_midstream();
      alternate_extremes();
      // Flush the last samples through the pipeline
      test_name = "drain";
      repeat (drain_cycles) drive_cycle('0, 1'b1);
      // Assertion failures on the last edge are only visible here
      if (error_count == 0 && i_butterworth_iir.i_properties.assert_errors == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
